/* files.f */
design/rv_isa_pkg.sv
design/mem_stage_pkg.sv
design/mem_access.sv
design/result_path.sv
design/flow_resolve.sv
design/mem_wb_reg.sv
design/mem_stage.sv
sim/tb_clock.sv
sim/mem_stage_tb.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module mem_stage_tb -o mem_stage_sim
output=$(./obj_dir/mem_stage_sim)
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"; then
  exit 0
fi
exit 1

/* sim/mem_stage_tb.sv */
module mem_stage_tb
  import rv_isa_pkg::*;
  import mem_stage_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 16;
  localparam int TEST_CYCLES  = 600;
  // Twice the test length plus reset
  localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES + RESET_CYCLES;
  localparam logic [31:0] SEED = 32'h1b20bd9d;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam funct3_t LOAD_KINDS [5] = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};

  logic         clk;
  logic         rst_n;
  logic         stall;
  ex_mem_t      ex_in;
  branch_info_t br_in;
  dmem_req_t    dmem;
  word_t        dmem_rdata;
  wb_t          wb;
  word_t        result_mem;
  word_t        load_data_mem;
  ras_upd_t     ras;
  redirect_t    redirect;

  // 256-word memory model
  word_t mem [256];
  word_t rng_state;
  int    errors;
  int    checks;
  int    cycles;
  // Expected writeback state, tracked across edges
  wb_t   exp_wb;
  logic  checking;

  tb_clock u_clock (.clk(clk));

  mem_stage u_mem_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (stall),
    .ex            (ex_in),
    .br            (br_in),
    .dmem          (dmem),
    .dmem_rdata    (dmem_rdata),
    .wb            (wb),
    .result_mem    (result_mem),
    .load_data_mem (load_data_mem),
    .ras           (ras),
    .redirect      (redirect)
  );

  // Read answers in the same cycle
  assign dmem_rdata = mem[dmem.raddr[9:2]];

  // Byte lane writes at the rising edge
  always @(posedge clk) begin
    if (dmem.we) begin
      for (int k = 0; k < 4; k++) begin
        if (dmem.wstrb[k]) begin
          mem[dmem.waddr[9:2]][8*k +: 8] <= dmem.wdata[8*k +: 8];
        end
      end
    end
  end

  // xorshift32 generator
  function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic wb_t reset_wb();
    wb_t r;
    r = '0;
    r.instr = I_NOP;
    r.trap_code = TRAP_NONE;
    return r;
  endfunction

  // Halfword needs bit 0 clear, word needs both low bits clear
  function automatic logic ref_misalign(ex_mem_t e);
    if (!(e.mem_read || e.mem_write)) begin
      return 1'b0;
    end
    case (e.funct3[1:0])
      2'd1:    return e.alu_result[0];
      2'd2:    return |e.alu_result[1:0];
      default: return 1'b0;
    endcase
  endfunction

  function automatic dmem_req_t ref_dmem(ex_mem_t e);
    dmem_req_t r;
    logic      trap_any;
    word_t     data;
    strb_t     mask;
    trap_any = e.trap || ref_misalign(e);
    case (e.funct3[1:0])
      2'd0: begin
        data = {24'h0, e.rs2_data[7:0]};
        mask = 4'h1;
      end
      2'd1: begin
        data = {16'h0, e.rs2_data[15:0]};
        mask = 4'h3;
      end
      default: begin
        data = e.rs2_data;
        mask = 4'hf;
      end
    endcase
    r.ren   = e.mem_read && !trap_any;
    r.we    = e.mem_write && !trap_any;
    r.raddr = e.alu_result & ~32'h3;
    r.waddr = e.alu_result & ~32'h3;
    r.wdata = data << (8 * int'(e.alu_result[1:0]));
    r.wstrb = e.mem_write ? strb_t'(mask << e.alu_result[1:0]) : 4'h0;
    return r;
  endfunction

  // Extension of the addressed byte or halfword
  function automatic word_t ref_load(ex_mem_t e, word_t w);
    word_t s;
    s = w >> (8 * int'(e.alu_result[1:0]));
    case (e.funct3)
      F3_B:    return {{24{s[7]}}, s[7:0]};
      F3_H:    return {{16{s[15]}}, s[15:0]};
      F3_BU:   return {24'h0, s[7:0]};
      F3_HU:   return {16'h0, s[15:0]};
      default: return w;
    endcase
  endfunction

  function automatic word_t ref_result(ex_mem_t e, word_t ld);
    case (e.res_src)
      RES_MEM: return ld;
      RES_PC4: return e.pc_plus4;
      RES_TGT: return e.jb_target;
      default: return e.alu_result;
    endcase
  endfunction

  function automatic ras_upd_t ref_ras(ex_mem_t e, branch_info_t b);
    ras_upd_t r;
    r.push = (e.instr[6:0] == OP_JAL || b.is_jalr) && (e.instr[11:7] != 5'd0);
    r.push_addr = e.pc_plus4;
    r.pop = b.is_jalr;
    return r;
  endfunction

  function automatic redirect_t ref_redirect(ex_mem_t e, branch_info_t b);
    redirect_t r;
    logic      br_miss;
    br_miss = b.is_branch && (b.branch_taken != b.bpred_taken);
    r.jalr_mispredicted = b.is_jalr && (!b.bpred_taken || b.pred_target != e.jb_target);
    r.mispredicted = br_miss || r.jalr_mispredicted;
    r.target = (br_miss && !b.branch_taken) ? e.pc_plus4 : e.jb_target;
    return r;
  endfunction

  function automatic wb_t ref_wb(ex_mem_t e, word_t ld);
    wb_t  r;
    logic mis;
    mis = ref_misalign(e);
    r.valid      = e.valid;
    r.reg_write  = e.reg_write && !(e.trap || mis);
    r.res_src    = e.res_src;
    r.instr      = e.instr;
    r.rd         = e.rd;
    r.funct3     = e.funct3;
    r.alu_result = e.alu_result;
    r.load_data  = ld;
    r.pc_plus4   = e.pc_plus4;
    r.jb_target  = e.jb_target;
    r.trap       = e.trap || mis;
    r.trap_code  = mis ? TRAP_LDST_MISALIGN : e.trap_code;
    return r;
  endfunction

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_strb(string name, strb_t got, strb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_trap_code(string name, trap_code_t got, trap_code_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_wb(string name, wb_t got, wb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_redirect(string name, redirect_t got, redirect_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Next wb from inputs held since the falling edge
  // mem still shows its old contents here, writes land by NBA
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_wb = reset_wb();
    end else if (!stall) begin
      exp_wb = ref_wb(ex_in, ref_load(ex_in, mem[ex_in.alu_result[9:2]]));
    end
    checking = 1'b1;
  end

  // Compare before the new stimulus takes effect
  always @(negedge clk) begin
    dmem_req_t ed;
    word_t     ld;
    ras_upd_t  er;
    if (checking) begin
      ed = ref_dmem(ex_in);
      ld = ref_load(ex_in, mem[ex_in.alu_result[9:2]]);
      er = ref_ras(ex_in, br_in);
      check_bit("dmem.ren", dmem.ren, ed.ren);
      check_bit("dmem.we", dmem.we, ed.we);
      check_word("dmem.raddr", dmem.raddr, ed.raddr);
      check_word("dmem.waddr", dmem.waddr, ed.waddr);
      check_word("dmem.wdata", dmem.wdata, ed.wdata);
      check_strb("dmem.wstrb", dmem.wstrb, ed.wstrb);
      check_word("load_data_mem", load_data_mem, ld);
      check_word("result_mem", result_mem, ref_result(ex_in, ld));
      check_bit("ras.push", ras.push, er.push);
      check_bit("ras.pop", ras.pop, er.pop);
      check_word("ras.push_addr", ras.push_addr, er.push_addr);
      check_redirect("redirect", redirect, ref_redirect(ex_in, br_in));
      check_wb("wb", wb, exp_wb);
      check_trap_code("wb.trap_code", wb.trap_code, exp_wb.trap_code);
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout, run passed %0d cycles without finishing", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // New inputs at the falling edge, NBA keeps the checker on old values
  task automatic drive(ex_mem_t e, branch_info_t b, logic s);
    @(negedge clk);
    ex_in <= e;
    br_in <= b;
    stall <= s;
  endtask

  // Random ALU style instruction with no memory access
  function automatic ex_mem_t rand_ex();
    ex_mem_t e;
    e = '0;
    e.valid      = 1'b1;
    e.reg_write  = 1'b1;
    e.res_src    = RES_ALU;
    e.instr      = next_rand();
    e.rd         = e.instr[11:7];
    e.funct3     = e.instr[14:12];
    e.alu_result = next_rand();
    e.rs2_data   = next_rand();
    e.pc_plus4   = next_rand();
    e.jb_target  = next_rand();
    e.trap_code  = TRAP_NONE;
    return e;
  endfunction

  function automatic word_t make_addr(logic [7:0] idx, logic [1:0] off);
    word_t r;
    r = next_rand();
    return {r[31:10], idx, off};
  endfunction

  initial begin
    ex_mem_t      e;
    branch_info_t b;
    branch_info_t nob;
    word_t        r;
    word_t        old_word;
    word_t        merged;
    dmem_req_t    req;
    logic [7:0]   idx;
    rng_state = SEED;
    errors = 0;
    checks = 0;
    cycles = 0;
    checking = 1'b0;
    exp_wb = reset_wb();
    e = '0;
    e.instr = I_NOP;
    nob = '0;
    rst_n <= 1'b0;
    // Held through reset so no edge captures before the reset check
    stall <= 1'b1;
    ex_in <= e;
    br_in <= '0;
    // Fill pattern spread over every address bit
    for (int i = 0; i < 256; i++) begin
      mem[i] <= (word_t'(i) * 32'h9e3779b1) ^ {word_t'(i) << 22} ^ word_t'(i);
    end

    // Stalled edges after reset must keep the reset contents
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n <= 1'b1;
    drive(ex_in, nob, 1'b1);
    drive(rand_ex(), nob, 1'b1);
    check_wb("wb after reset", wb, reset_wb());

    // Stores of each size at each aligned offset, then word readback
    for (int sz = 0; sz < 3; sz++) begin
      for (int off = 0; off < 4; off += (1 << sz)) begin
        repeat (3) begin
          r = next_rand();
          idx = r[7:0];
          e = rand_ex();
          e.mem_write = 1'b1;
          e.reg_write = 1'b0;
          e.funct3 = funct3_t'(sz);
          e.alu_result = make_addr(idx, 2'(off));
          old_word = mem[idx];
          req = ref_dmem(e);
          for (int k = 0; k < 4; k++) begin
            merged[8*k +: 8] = req.wstrb[k] ? req.wdata[8*k +: 8] : old_word[8*k +: 8];
          end
          drive(e, nob, 1'b0);
          e.mem_write = 1'b0;
          e.mem_read = 1'b1;
          e.funct3 = F3_W;
          e.res_src = RES_MEM;
          e.alu_result = make_addr(idx, 2'b00);
          drive(e, nob, 1'b0);
          @(posedge clk);
          check_word("load_data_mem readback", load_data_mem, merged);
        end
      end
    end

    // Loads of all kinds at aligned offsets
    repeat (120) begin
      r = next_rand();
      e = rand_ex();
      e.mem_read = 1'b1;
      e.res_src = RES_MEM;
      e.funct3 = LOAD_KINDS[int'(r % 5)];
      case (e.funct3[1:0])
        2'd0:    e.alu_result = make_addr(r[15:8], r[17:16]);
        2'd1:    e.alu_result = make_addr(r[15:8], {r[16], 1'b0});
        default: e.alu_result = make_addr(r[15:8], 2'b00);
      endcase
      drive(e, nob, 1'b0);
    end

    // Misaligned accesses and traps from execute
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      e = rand_ex();
      e.mem_read = r[20];
      e.mem_write = !r[20];
      case (i % 3)
        0: begin
          e.funct3 = F3_H;
          e.alu_result = make_addr(r[7:0], {r[8], 1'b1});
        end
        1: begin
          e.funct3 = F3_W;
          e.alu_result = make_addr(r[7:0], (r[9:8] == 2'b00) ? 2'b01 : r[9:8]);
        end
        default: begin
          e.funct3 = F3_W;
          e.alu_result = make_addr(r[7:0], 2'b00);
          e.trap = 1'b1;
        end
      endcase
      drive(e, nob, 1'b0);
    end

    // JAL, JALR and branches with random predictions
    repeat (150) begin
      r = next_rand();
      e = rand_ex();
      b = '0;
      e.res_src = res_src_t'({1'b0, r[1:0]});
      b.bpred_taken = r[4];
      b.branch_taken = r[5];
      b.pred_target = r[6] ? e.jb_target : next_rand();
      // rd of x0 now and then
      if (r[7]) begin
        e.instr[11:7] = 5'd0;
        e.rd = 5'd0;
      end
      case (int'(r[31:16] % 3))
        0: e.instr[6:0] = OP_JAL;
        1: begin
          e.instr[6:0] = OP_JALR;
          b.is_jalr = 1'b1;
        end
        default: begin
          e.instr[6:0] = OP_BRANCH;
          b.is_branch = 1'b1;
        end
      endcase
      drive(e, b, 1'b0);
    end

    // Random stall with a mix of loads and ALU ops
    repeat (200) begin
      r = next_rand();
      e = rand_ex();
      if (r[3]) begin
        e.mem_read = 1'b1;
        e.res_src = RES_MEM;
        e.funct3 = F3_W;
        e.alu_result = make_addr(r[15:8], 2'b00);
      end
      drive(e, nob, (r % 3) == 0);
    end

    // Let the last edge be checked
    drive(rand_ex(), nob, 1'b0);
    @(negedge clk);
    @(posedge clk);
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sim/tb_clock.sv */
module tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  // Half of the 20 ns period
  localparam int HALF_PERIOD = 10;

  // Starts low so the first rising edge lands at 10 ns
  initial begin
    clk = 1'b0;
  end

  always #HALF_PERIOD clk = ~clk;

endmodule

/* design/mem_stage.sv */
module mem_stage
  import rv_isa_pkg::*;
  import mem_stage_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         stall,

  // From execute
  input  ex_mem_t      ex,
  input  branch_info_t br,

  // Data memory, read data returns in the same cycle
  output dmem_req_t    dmem,
  input  word_t        dmem_rdata,

  // To writeback
  output wb_t          wb,

  // Forwarding to execute
  output word_t        result_mem,
  output word_t        load_data_mem,

  // Control flow back to fetch
  output ras_upd_t     ras,
  output redirect_t    redirect
);

  // Misalignment found by the address check
  logic misalign;

  // Address check, store formatting and memory request
  mem_access u_mem_access (
    .ex       (ex),
    .dmem     (dmem),
    .misalign (misalign)
  );

  // Load extension and forwarding value
  result_path u_result_path (
    .ex         (ex),
    .dmem_rdata (dmem_rdata),
    .load_data  (load_data_mem),
    .result     (result_mem)
  );

  // Return stack and redirect
  flow_resolve u_flow_resolve (
    .ex       (ex),
    .br       (br),
    .ras      (ras),
    .redirect (redirect)
  );

  // Pipeline register into writeback
  mem_wb_reg u_mem_wb_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .ex        (ex),
    .misalign  (misalign),
    .load_data (load_data_mem),
    .wb        (wb)
  );

endmodule

/* design/mem_wb_reg.sv */
module mem_wb_reg
  import rv_isa_pkg::*;
  import mem_stage_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    stall,
  input  ex_mem_t ex,
  input  logic    misalign,
  input  word_t   load_data,
  output wb_t     wb
);

  // Next writeback contents
  wb_t wb_next;

  // Trap after merging the local misalignment
  logic trap_next;

  assign trap_next = ex.trap | misalign;

  // Build the next bundle
  always_comb begin
    wb_next.valid      = ex.valid;

    // A trapped instruction must not touch the register file
    wb_next.reg_write  = ex.reg_write && !trap_next;

    wb_next.res_src    = ex.res_src;
    wb_next.instr      = ex.instr;
    wb_next.rd         = ex.rd;
    wb_next.funct3     = ex.funct3;
    wb_next.alu_result = ex.alu_result;

    // Already extended in this stage
    wb_next.load_data  = load_data;

    wb_next.pc_plus4   = ex.pc_plus4;
    wb_next.jb_target  = ex.jb_target;
    wb_next.trap       = trap_next;

    // Local misalignment wins over the cause from execute
    if (misalign) begin
      wb_next.trap_code = TRAP_LDST_MISALIGN;
    end else begin
      wb_next.trap_code = ex.trap_code;
    end
  end

  // MEM/WB register
  // Stall holds the whole bundle so the WB instruction stays put
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb <= WB_RST;
    end else if (!stall) begin
      wb <= wb_next;
    end
  end

endmodule

/* design/flow_resolve.sv */
module flow_resolve
  import rv_isa_pkg::*;
  import mem_stage_pkg::*;
(
  input  ex_mem_t      ex,
  input  branch_info_t br,
  output ras_upd_t     ras,
  output redirect_t    redirect
);

  // Fields decoded from the raw instruction
  logic [6:0] opcode;
  reg_addr_t  rd;
  logic       is_jal;

  // Individual misprediction flags
  logic branch_mispred;
  logic jalr_mispred;

  assign opcode = ex.instr[6:0];
  assign rd     = ex.instr[11:7];
  assign is_jal = (opcode == OP_JAL);

  // Return stack update
  // A call links into a real register, rd of x0 is a plain jump
  always_comb begin
    ras.push      = (is_jal || br.is_jalr) && (rd != '0);
    ras.push_addr = ex.pc_plus4;
    // Every JALR is treated as a return
    ras.pop       = br.is_jalr;
  end

  // Conditional branch went the other way from the prediction
  assign branch_mispred = br.is_branch && (br.branch_taken != br.bpred_taken);

  // JALR target is only known here
  // Wrong if fetch did not predict a jump, or jumped elsewhere
  assign jalr_mispred = br.is_jalr &&
                        (!br.bpred_taken || (br.pred_target != ex.jb_target));

  // Redirect
  always_comb begin
    redirect.mispredicted      = branch_mispred | jalr_mispred;
    redirect.jalr_mispredicted = jalr_mispred;

    // Predicted taken but fell through, resume at the next instruction
    if (branch_mispred && !br.branch_taken) begin
      redirect.target = ex.pc_plus4;
    end else begin
      // taken branch or JALR goes to the resolved target
      redirect.target = ex.jb_target;
    end
  end

endmodule

/* design/result_path.sv */
module result_path
  import rv_isa_pkg::*;
  import mem_stage_pkg::*;
(
  input  ex_mem_t ex,
  input  word_t   dmem_rdata,
  output word_t   load_data,
  output word_t   result
);

  // Byte offset of the load inside the returned word
  logic [1:0] offset;

  // Read word with the addressed byte moved to lane 0
  word_t rdata_shifted;

  // Candidate narrow values
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  assign offset        = ex.alu_result[1:0];
  assign rdata_shifted = dmem_rdata >> {offset, 3'b000};
  assign ld_byte       = rdata_shifted[7:0];
  assign ld_half       = rdata_shifted[15:0];

  // Load extension
  // Signed kinds replicate the top bit, unsigned kinds pad with zero
  always_comb begin
    case (ex.funct3)
      F3_B:    load_data = {{(XLEN-8){ld_byte[7]}}, ld_byte};
      F3_H:    load_data = {{(XLEN-16){ld_half[15]}}, ld_half};
      F3_BU:   load_data = {{(XLEN-8){1'b0}}, ld_byte};
      F3_HU:   load_data = {{(XLEN-16){1'b0}}, ld_half};
      F3_W:    load_data = dmem_rdata;
      // Unused encodings return the raw word
      default: load_data = dmem_rdata;
    endcase
  end

  // Forwarding result
  // Same selection as writeback, so a dependent op in execute
  // sees the final rd value one stage early
  always_comb begin
    case (ex.res_src)
      RES_MEM: result = load_data;
      // Link address of JAL and JALR
      RES_PC4: result = ex.pc_plus4;
      // AUIPC style target
      RES_TGT: result = ex.jb_target;
      RES_ALU: result = ex.alu_result;
      default: result = ex.alu_result;
    endcase
  end

endmodule

/* design/mem_access.sv */
module mem_access
  import rv_isa_pkg::*;
  import mem_stage_pkg::*;
(
  input  ex_mem_t   ex,
  output dmem_req_t dmem,
  output logic      misalign
);

  // Byte offset of the access inside its word
  logic [1:0] offset;

  // Store data masked to the access size, before lane shift
  word_t st_data;

  // Strobes for the access size at offset 0
  strb_t size_mask;

  // Any trap, from execute or found here
  logic trap_any;

  assign offset = ex.alu_result[1:0];

  // Misalignment check
  // Only halfword and word accesses can be misaligned
  always_comb begin
    misalign = 1'b0;
    if (ex.mem_read || ex.mem_write) begin
      case (ex.funct3[1:0])
        F3_H[1:0]: misalign = offset[0];
        F3_W[1:0]: misalign = |offset;
        default:   misalign = 1'b0;
      endcase
    end
  end

  assign trap_any = ex.trap | misalign;

  // Store data and strobe by size
  // Bits above the access size are cleared so unused lanes carry zero
  always_comb begin
    case (ex.funct3[1:0])
      F3_B[1:0]: begin
        st_data   = {{(XLEN-8){1'b0}}, ex.rs2_data[7:0]};
        size_mask = 4'b0001;
      end
      F3_H[1:0]: begin
        st_data   = {{(XLEN-16){1'b0}}, ex.rs2_data[15:0]};
        size_mask = 4'b0011;
      end
      default: begin
        st_data   = ex.rs2_data;
        size_mask = 4'b1111;
      end
    endcase
  end

  // Memory request
  always_comb begin
    // No access leaves the stage once a trap is pending
    dmem.ren   = ex.mem_read && !trap_any;
    dmem.we    = ex.mem_write && !trap_any;

    // Memory is word addressed, lanes are picked by strobes
    dmem.raddr = {ex.alu_result[XLEN-1:2], 2'b00};
    dmem.waddr = {ex.alu_result[XLEN-1:2], 2'b00};

    // Move the data into its byte lanes
    dmem.wdata = st_data << {offset, 3'b000};

    // Strobes stay quiet for non-stores
    dmem.wstrb = ex.mem_write ? strb_t'(size_mask << offset) : '0;
  end

endmodule

/* design/mem_stage_pkg.sv */
package mem_stage_pkg;
  import rv_isa_pkg::*;

  // Instruction state handed over from execute
  typedef struct packed {
    logic       valid;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    res_src_t   res_src;
    instr_t     instr;
    reg_addr_t  rd;
    funct3_t    funct3;
    word_t      alu_result;   // Also the effective address for loads and stores
    word_t      rs2_data;
    word_t      pc_plus4;
    word_t      jb_target;
    logic       trap;
    trap_code_t trap_code;
  } ex_mem_t;

  // Branch resolution and prediction made at fetch
  typedef struct packed {
    logic  is_branch;
    logic  is_jalr;
    logic  branch_taken;
    logic  bpred_taken;
    word_t pred_target;
  } branch_info_t;

  // Data memory request, word aligned
  typedef struct packed {
    logic  ren;
    word_t raddr;
    logic  we;
    word_t waddr;
    word_t wdata;
    strb_t wstrb;
  } dmem_req_t;

  // State captured into the writeback stage
  typedef struct packed {
    logic       valid;
    logic       reg_write;
    res_src_t   res_src;
    instr_t     instr;
    reg_addr_t  rd;
    funct3_t    funct3;
    word_t      alu_result;
    word_t      load_data;
    word_t      pc_plus4;
    word_t      jb_target;
    logic       trap;
    trap_code_t trap_code;
  } wb_t;

  // Return address stack update
  typedef struct packed {
    logic  push;
    word_t push_addr;
    logic  pop;
  } ras_upd_t;

  // Fetch redirect on misprediction
  typedef struct packed {
    logic  mispredicted;
    logic  jalr_mispredicted;
    word_t target;
  } redirect_t;

  // Writeback contents after reset, a retired NOP with no effect
  localparam wb_t WB_RST = '{
    valid:      1'b0,
    reg_write:  1'b0,
    res_src:    RES_ALU,
    instr:      I_NOP,
    rd:         '0,
    funct3:     '0,
    alu_result: '0,
    load_data:  '0,
    pc_plus4:   '0,
    jb_target:  '0,
    trap:       1'b0,
    trap_code:  TRAP_NONE
  };

endpackage

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Base integer data width, fixed for RV32
  localparam int XLEN = 32;

  // Data and address word
  typedef logic [XLEN-1:0] word_t;

  // Raw instruction word
  typedef logic [31:0] instr_t;

  // Register file index
  typedef logic [4:0] reg_addr_t;

  // Load/store size and sign field
  typedef logic [2:0] funct3_t;

  // One strobe bit per byte lane
  typedef logic [XLEN/8-1:0] strb_t;

  // Major opcode of JAL
  localparam logic [6:0] OP_JAL = 7'b1101111;

  // Load/store funct3 encodings
  // Bits [1:0] give the access size, bit 2 selects zero extension
  localparam funct3_t F3_B  = 3'd0;
  localparam funct3_t F3_H  = 3'd1;
  localparam funct3_t F3_W  = 3'd2;
  localparam funct3_t F3_BU = 3'd4;
  localparam funct3_t F3_HU = 3'd5;

  // Canonical NOP, addi x0, x0, 0
  localparam instr_t I_NOP = 32'h00000013;

  // Trap causes carried down the pipeline
  typedef enum logic [1:0] {
    TRAP_NONE          = 2'd0,
    TRAP_LDST_MISALIGN = 2'd1
  } trap_code_t;

  // Source of the value written back to rd
  typedef enum logic [2:0] {
    RES_ALU = 3'd0,
    RES_MEM = 3'd1,
    RES_PC4 = 3'd2,
    RES_TGT = 3'd3
  } res_src_t;

endpackage
